//--- run.sh
#!/bin/sh
# build and run the LSU regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f sim.f -o tb_lsu
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_lsu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Regression passed$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim.f
src/lsu_pkg.sv
src/chan_reg.sv
src/load_unit.sv
src/store_unit.sv
src/lsu.sv
src/data_ram.sv
src/lsu_top.sv
tests/tb_lsu.sv

//--- src/chan_reg.sv
`default_nettype none

module chan_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  wire           clk,
  input  wire           rstn,
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_data
);

  payload_t   entry [2];
  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       push;
  logic       pop;

  // ready from occupancy only
  assign in_ready  = (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign out_data  = entry[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) entry[wr_ptr] <= in_data;
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rstn)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

//--- src/data_ram.sv
`default_nettype none

module data_ram (
  input  wire              clk,
  input  wire              rstn,
  input  wire lsu_pkg::ar_t ar,
  input  wire              ar_valid,
  output logic             ar_ready,
  output lsu_pkg::r_t      r,
  output logic             r_valid,
  input  wire              r_ready,
  input  wire lsu_pkg::aw_t aw,
  input  wire              aw_valid,
  output logic             aw_ready,
  input  wire lsu_pkg::w_t w,
  input  wire              w_valid,
  output logic             w_ready,
  output logic             b_valid,
  input  wire              b_ready
);

  logic [31:0] mem [lsu_pkg::RAM_WORDS] = '{default: '0};

  lsu_pkg::aw_t                  aw_q;
  lsu_pkg::w_t                   w_q;
  logic                          aw_held;
  logic                          w_held;
  logic                          ar_fire;
  logic                          do_write;
  logic [lsu_pkg::RAM_IDX_W-1:0] rd_idx;
  logic [lsu_pkg::RAM_IDX_W-1:0] wr_idx;

  // word index from addr[11:2]
  assign rd_idx = ar.addr[2 +: lsu_pkg::RAM_IDX_W];
  assign wr_idx = aw_q.addr[2 +: lsu_pkg::RAM_IDX_W];

  assign ar_ready = !r_valid || r_ready;
  assign aw_ready = !aw_held;
  assign w_ready  = !w_held;

  assign ar_fire  = ar_valid && ar_ready;
  // both halves present and the B slot free
  assign do_write = aw_held && w_held && (!b_valid || b_ready);

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) aw_held <= 1'b1;
      else if (do_write) aw_held <= 1'b0;
      if (w_valid && w_ready) w_held <= 1'b1;
      else if (do_write) w_held <= 1'b0;
      if (do_write) b_valid <= 1'b1;
      else if (b_ready) b_valid <= 1'b0;
      if (ar_fire) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) aw_q <= aw;
    if (w_valid && w_ready) w_q <= w;
  end

  // read sees the contents before a same-edge write
  always_ff @(posedge clk) begin
    if (ar_fire) r.data <= mem[rd_idx];
    if (do_write) begin
      for (int i = 0; i < 4; i++) begin
        if (w_q.strb[i]) mem[wr_idx][8*i +: 8] <= w_q.data[8*i +: 8];
      end
    end
  end

  // a stalled B leaves the parked write's word untouched
  a_no_write_on_b_stall: assert property (@(posedge clk) disable iff (rstn)
    (b_valid && !b_ready && aw_held) |=> $stable(mem[wr_idx]));

endmodule

`default_nettype wire

//--- src/load_unit.sv
`default_nettype none

module load_unit (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire lsu_pkg::ld_req_t    req,
  input  wire                      req_valid,
  output logic                     req_ready,
  output logic [31:0]              data,
  output logic                     rsp_valid,
  input  wire                      rsp_ready,
  output lsu_pkg::ar_t             ar,
  output logic                     ar_valid,
  input  wire                      ar_ready,
  input  wire lsu_pkg::r_t         r,
  input  wire                      r_valid,
  output logic                     r_ready
);

  lsu_pkg::ld_meta_t               meta_q [lsu_pkg::LD_DEPTH];
  lsu_pkg::ld_meta_t               head;
  logic [lsu_pkg::LD_PTR_W-1:0]    wr_ptr;
  logic [lsu_pkg::LD_PTR_W-1:0]    rd_ptr;
  logic [lsu_pkg::LD_CNT_W-1:0]    count;
  logic                            has_room;
  logic                            push;
  logic                            pop;
  logic [31:0]                     shifted;

  assign has_room = (count < lsu_pkg::LD_DEPTH);

  // AR leaves in the same cycle as the request
  assign ar.addr   = req.addr;
  assign ar_valid  = req_valid && has_room;
  assign req_ready = has_room && ar_ready;

  assign rsp_valid = r_valid;
  assign r_ready   = rsp_ready;

  assign push = req_valid && req_ready;
  assign pop  = r_valid && r_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == lsu_pkg::LD_PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == lsu_pkg::LD_PTR_LAST) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) meta_q[wr_ptr] <= '{align: req.addr[1:0], func: req.func};
  end

  // shift down by the byte offset, then extend
  always_comb begin
    head    = meta_q[rd_ptr];
    shifted = r.data >> {head.align, 3'b000};
    case (head.func)
      lsu_pkg::ld_b:  data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::ld_bu: data = {24'b0, shifted[7:0]};
      lsu_pkg::ld_h:  data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::ld_hu: data = {16'b0, shifted[15:0]};
      default:        data = shifted;
    endcase
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rstn)
    count <= lsu_pkg::LD_DEPTH);

  // memory must not answer a load that was never issued
  a_r_has_meta: assert property (@(posedge clk) disable iff (rstn)
    r_valid |-> (count != '0));

endmodule

`default_nettype wire

//--- src/lsu.sv
`default_nettype none

module lsu (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire lsu_pkg::ld_req_t ld_req,
  input  wire                   ld_req_valid,
  output logic                  ld_req_ready,
  output logic [31:0]           ld_data,
  output logic                  ld_rsp_valid,
  input  wire                   ld_rsp_ready,
  input  wire lsu_pkg::st_req_t st_req,
  input  wire                   st_req_valid,
  output logic                  st_req_ready,
  output logic                  st_rsp_valid,
  input  wire                   st_rsp_ready,
  output lsu_pkg::ar_t          ar,
  output logic                  ar_valid,
  input  wire                   ar_ready,
  input  wire lsu_pkg::r_t      r,
  input  wire                   r_valid,
  output logic                  r_ready,
  output lsu_pkg::aw_t          aw,
  output logic                  aw_valid,
  input  wire                   aw_ready,
  output lsu_pkg::w_t           w,
  output logic                  w_valid,
  input  wire                   w_ready,
  input  wire                   b_valid,
  output logic                  b_ready
);

  lsu_pkg::ar_t lu_ar;
  logic         lu_ar_valid;
  logic         lu_ar_ready;
  lsu_pkg::r_t  lu_r;
  logic         lu_r_valid;
  logic         lu_r_ready;
  lsu_pkg::aw_t su_aw;
  logic         su_aw_valid;
  logic         su_aw_ready;
  lsu_pkg::w_t  su_w;
  logic         su_w_valid;
  logic         su_w_ready;

  load_unit u_load (
    .clk       (clk),
    .rstn      (rstn),
    .req       (ld_req),
    .req_valid (ld_req_valid),
    .req_ready (ld_req_ready),
    .data      (ld_data),
    .rsp_valid (ld_rsp_valid),
    .rsp_ready (ld_rsp_ready),
    .ar        (lu_ar),
    .ar_valid  (lu_ar_valid),
    .ar_ready  (lu_ar_ready),
    .r         (lu_r),
    .r_valid   (lu_r_valid),
    .r_ready   (lu_r_ready)
  );

  store_unit u_store (
    .clk       (clk),
    .rstn      (rstn),
    .req       (st_req),
    .req_valid (st_req_valid),
    .req_ready (st_req_ready),
    .rsp_valid (st_rsp_valid),
    .rsp_ready (st_rsp_ready),
    .aw        (su_aw),
    .aw_valid  (su_aw_valid),
    .aw_ready  (su_aw_ready),
    .w         (su_w),
    .w_valid   (su_w_valid),
    .w_ready   (su_w_ready),
    .b_valid   (b_valid),
    .b_ready   (b_ready)
  );

  // register slices toward memory
  chan_reg #(.payload_t(lsu_pkg::ar_t)) u_ar_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (lu_ar_valid),
    .in_ready  (lu_ar_ready),
    .in_data   (lu_ar),
    .out_valid (ar_valid),
    .out_ready (ar_ready),
    .out_data  (ar)
  );

  chan_reg #(.payload_t(lsu_pkg::r_t)) u_r_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (r_valid),
    .in_ready  (r_ready),
    .in_data   (r),
    .out_valid (lu_r_valid),
    .out_ready (lu_r_ready),
    .out_data  (lu_r)
  );

  chan_reg #(.payload_t(lsu_pkg::aw_t)) u_aw_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (su_aw_valid),
    .in_ready  (su_aw_ready),
    .in_data   (su_aw),
    .out_valid (aw_valid),
    .out_ready (aw_ready),
    .out_data  (aw)
  );

  chan_reg #(.payload_t(lsu_pkg::w_t)) u_w_reg (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (su_w_valid),
    .in_ready  (su_w_ready),
    .in_data   (su_w),
    .out_valid (w_valid),
    .out_ready (w_ready),
    .out_data  (w)
  );

endmodule

`default_nettype wire

//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int LD_DEPTH  = 4;
  localparam int ST_DEPTH  = 4;
  localparam int RAM_WORDS = 1024;

  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam int LD_PTR_W  = $clog2(LD_DEPTH);
  localparam int LD_CNT_W  = $clog2(LD_DEPTH + 1);
  localparam int ST_CNT_W  = $clog2(ST_DEPTH + 1);

  localparam logic [LD_PTR_W-1:0] LD_PTR_LAST = LD_PTR_W'(LD_DEPTH - 1);

  // riscv funct3 coding
  typedef enum logic [2:0] {
    ld_b  = 3'b000,
    ld_h  = 3'b001,
    ld_w  = 3'b010,
    ld_bu = 3'b100,
    ld_hu = 3'b101
  } ld_func_t;

  typedef enum logic [2:0] {
    st_b = 3'b000,
    st_h = 3'b001,
    st_w = 3'b010
  } st_func_t;

  typedef struct packed {
    logic [31:0] addr;
    ld_func_t    func;
  } ld_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    st_func_t    func;
  } st_req_t;

  // memory side channels
  typedef struct packed {
    logic [31:0] addr;
  } ar_t;

  typedef struct packed {
    logic [31:0] addr;
  } aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } w_t;

  typedef struct packed {
    logic [31:0] data;
  } r_t;

  // per outstanding load
  typedef struct packed {
    logic [1:0] align;
    ld_func_t   func;
  } ld_meta_t;

endpackage

`default_nettype wire

//--- src/lsu_top.sv
`default_nettype none

module lsu_top (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire lsu_pkg::ld_req_t ld_req,
  input  wire                   ld_req_valid,
  output logic                  ld_req_ready,
  output logic [31:0]           ld_data,
  output logic                  ld_rsp_valid,
  input  wire                   ld_rsp_ready,
  input  wire lsu_pkg::st_req_t st_req,
  input  wire                   st_req_valid,
  output logic                  st_req_ready,
  output logic                  st_rsp_valid,
  input  wire                   st_rsp_ready
);

  lsu_pkg::ar_t ar;
  logic         ar_valid;
  logic         ar_ready;
  lsu_pkg::r_t  r;
  logic         r_valid;
  logic         r_ready;
  lsu_pkg::aw_t aw;
  logic         aw_valid;
  logic         aw_ready;
  lsu_pkg::w_t  w;
  logic         w_valid;
  logic         w_ready;
  logic         b_valid;
  logic         b_ready;

  lsu u_lsu (
    .clk          (clk),
    .rstn         (rstn),
    .ld_req       (ld_req),
    .ld_req_valid (ld_req_valid),
    .ld_req_ready (ld_req_ready),
    .ld_data      (ld_data),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp_ready (ld_rsp_ready),
    .st_req       (st_req),
    .st_req_valid (st_req_valid),
    .st_req_ready (st_req_ready),
    .st_rsp_valid (st_rsp_valid),
    .st_rsp_ready (st_rsp_ready),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r            (r),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b_valid      (b_valid),
    .b_ready      (b_ready)
  );

  data_ram u_ram (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

endmodule

`default_nettype wire

//--- src/store_unit.sv
`default_nettype none

module store_unit (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire lsu_pkg::st_req_t req,
  input  wire                   req_valid,
  output logic                  req_ready,
  output logic                  rsp_valid,
  input  wire                   rsp_ready,
  output lsu_pkg::aw_t          aw,
  output logic                  aw_valid,
  input  wire                   aw_ready,
  output lsu_pkg::w_t           w,
  output logic                  w_valid,
  input  wire                   w_ready,
  input  wire                   b_valid,
  output logic                  b_ready
);

  logic [1:0]                   off;
  logic [3:0]                   mask;
  logic [31:0]                  data_al;
  logic [3:0]                   strb_al;
  logic [lsu_pkg::ST_CNT_W-1:0] outstanding;
  logic [lsu_pkg::ST_CNT_W-1:0] pending;
  logic                         issue;
  logic                         b_fire;
  logic                         rsp_fire;

  always_comb begin
    off = req.addr[1:0];
    case (req.func)
      lsu_pkg::st_b: mask = 4'b0001;
      lsu_pkg::st_h: mask = 4'b0011;
      default:       mask = 4'b1111;
    endcase
    data_al = req.data << {off, 3'b000};
    strb_al = mask << off;
  end

  assign req_ready = !aw_valid && !w_valid && (outstanding < lsu_pkg::ST_DEPTH);
  assign b_ready   = (pending < lsu_pkg::ST_DEPTH);
  assign rsp_valid = (pending != '0);

  assign issue    = req_valid && req_ready;
  assign b_fire   = b_valid && b_ready;
  assign rsp_fire = rsp_valid && rsp_ready;

  // AW and W retire independently
  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      if (issue) aw_valid <= 1'b1;
      else if (aw_ready) aw_valid <= 1'b0;
      if (issue) w_valid <= 1'b1;
      else if (w_ready) w_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      aw.addr <= req.addr;
      w.data  <= data_al;
      w.strb  <= strb_al;
    end
  end

  // writes in flight, and B's waiting to be reported
  always_ff @(posedge clk) begin
    if (rstn) begin
      outstanding <= '0;
      pending     <= '0;
    end else begin
      case ({issue, b_fire})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
      case ({b_fire, rsp_fire})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  a_outstanding_max: assert property (@(posedge clk) disable iff (rstn)
    outstanding <= lsu_pkg::ST_DEPTH);

endmodule

`default_nettype wire

//--- tests/tb_lsu.sv
`default_nettype none

module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  localparam int WORDS_USED = 32;
  localparam int SMALL_STORES = 48;
  localparam int SUB_WORDS = 16;
  localparam int BP_ROUNDS = 4;
  localparam int BP_STORES = 16;
  localparam int BP_LOADS = 32;
  localparam int TOTAL_OPS = 2 * WORDS_USED + SMALL_STORES + WORDS_USED + SUB_WORDS * 12
                             + BP_ROUNDS * (BP_STORES + BP_LOADS);

  logic             clk;
  logic             rstn;
  lsu_pkg::ld_req_t ld_req;
  logic             ld_req_valid;
  logic             ld_req_ready;
  logic [31:0]      ld_data;
  logic             ld_rsp_valid;
  logic             ld_rsp_ready;
  lsu_pkg::st_req_t st_req;
  logic             st_req_valid;
  logic             st_req_ready;
  logic             st_rsp_valid;
  logic             st_rsp_ready;

  // byte-wide mirror of the RAM, indexed by addr[11:0]
  logic [7:0]       model [4096];
  logic [31:0]      rng_state;
  lsu_pkg::ld_req_t ld_todo [$];
  lsu_pkg::st_req_t st_todo [$];
  logic [31:0]      exp_data [$];
  lsu_pkg::ld_req_t exp_req [$];
  logic             ld_go;
  logic             st_go;
  logic             throttle;
  int               st_queued;
  int               st_issued;
  int               st_done;

  lsu_top DUT (
    .clk          (clk),
    .rstn         (rstn),
    .ld_req       (ld_req),
    .ld_req_valid (ld_req_valid),
    .ld_req_ready (ld_req_ready),
    .ld_data      (ld_data),
    .ld_rsp_valid (ld_rsp_valid),
    .ld_rsp_ready (ld_rsp_ready),
    .st_req       (st_req),
    .st_req_valid (st_req_valid),
    .st_req_ready (st_req_ready),
    .st_rsp_valid (st_rsp_valid),
    .st_rsp_ready (st_rsp_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // upper address bits are random, the RAM ignores them
  function automatic logic [31:0] word_addr(input int word, input logic [1:0] off);
    logic [31:0] a;
    a = next_random();
    a[11:2] = 10'(word);
    a[1:0] = off;
    return a;
  endfunction

  // little-endian byte lanes
  function automatic logic [31:0] expected_load(input lsu_pkg::ld_req_t req);
    logic [11:0] base;
    logic [31:0] value;
    base = req.addr[11:0];
    case (req.func)
      lsu_pkg::ld_b:  value = {{24{model[base][7]}}, model[base]};
      lsu_pkg::ld_bu: value = {24'h0, model[base]};
      lsu_pkg::ld_h:  value = {{16{model[base + 12'd1][7]}}, model[base + 12'd1], model[base]};
      lsu_pkg::ld_hu: value = {16'h0, model[base + 12'd1], model[base]};
      default: value = {model[base + 12'd3], model[base + 12'd2], model[base + 12'd1], model[base]};
    endcase
    return value;
  endfunction

  task automatic apply_store(input lsu_pkg::st_req_t req);
    logic [11:0] base;
    int size;
    base = req.addr[11:0];
    case (req.func)
      lsu_pkg::st_b: size = 1;
      lsu_pkg::st_h: size = 2;
      default:       size = 4;
    endcase
    for (int i = 0; i < size; i++) begin
      model[base + 12'(i)] = req.data[8*i +: 8];
    end
  endtask

  task automatic stop_run(input string what);
    $display("Regression failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_load(input logic [31:0] got, input logic [31:0] exp,
                            input lsu_pkg::ld_req_t req);
    if (got !== exp) begin
      $display("error %0t: load addr %h func %b returned %h, expected %h",
               $time, req.addr, req.func, got, exp);
      stop_run("load data mismatch");
    end
  endtask

  task automatic check_store_count(input int got, input int exp);
    if (got != exp) begin
      $display("error %0t: %0d store responses seen, expected %0d", $time, got, exp);
      stop_run("store response count mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_run("handshake signal mismatch");
    end
  endtask

  task automatic queue_load(input logic [31:0] addr, input lsu_pkg::ld_func_t func);
    lsu_pkg::ld_req_t req;
    req.addr = addr;
    req.func = func;
    ld_todo.push_back(req);
  endtask

  task automatic queue_store(input logic [31:0] addr, input logic [31:0] data,
                             input lsu_pkg::st_func_t func);
    lsu_pkg::st_req_t req;
    req.addr = addr;
    req.data = data;
    req.func = func;
    st_todo.push_back(req);
    st_queued++;
  endtask

  task automatic queue_random_store(input bit words_too);
    logic [31:0] r;
    int sel;
    lsu_pkg::st_func_t f;
    logic [1:0] off;
    r = next_random();
    sel = words_too ? int'(r[1:0]) % 3 : int'(r[0]);
    case (sel)
      0: begin
        f = lsu_pkg::st_b;
        off = r[3:2];
      end
      1: begin
        f = lsu_pkg::st_h;
        off = {r[3], 1'b0};
      end
      default: begin
        f = lsu_pkg::st_w;
        off = 2'd0;
      end
    endcase
    queue_store(word_addr(int'(r[8:4]), off), next_random(), f);
  endtask

  task automatic queue_random_load();
    logic [31:0] r;
    lsu_pkg::ld_func_t f;
    logic [1:0] off;
    r = next_random();
    case (int'(r[2:0]) % 5)
      0: f = lsu_pkg::ld_b;
      1: f = lsu_pkg::ld_bu;
      2: f = lsu_pkg::ld_h;
      3: f = lsu_pkg::ld_hu;
      default: f = lsu_pkg::ld_w;
    endcase
    if (f == lsu_pkg::ld_w) off = 2'd0;
    else if (f == lsu_pkg::ld_h || f == lsu_pkg::ld_hu) off = {r[4], 1'b0};
    else off = r[4:3];
    queue_load(word_addr(int'(r[9:5]), off), f);
  endtask

  // drive at the falling edge, then sample what the next rising edge will take
  task automatic run_cycle();
    logic [31:0] r;
    @(negedge clk);
    if (ld_go) ld_req_valid = 1'b0;
    if (st_go) st_req_valid = 1'b0;
    if (!ld_req_valid && ld_todo.size() != 0) begin
      ld_req = ld_todo.pop_front();
      ld_req_valid = 1'b1;
    end
    if (!st_req_valid && st_todo.size() != 0) begin
      st_req = st_todo.pop_front();
      st_req_valid = 1'b1;
    end
    r = next_random();
    ld_rsp_ready = throttle ? r[0] : 1'b1;
    st_rsp_ready = throttle ? r[1] : 1'b1;
    #1;
    ld_go = ld_req_valid && ld_req_ready;
    st_go = st_req_valid && st_req_ready;
    if (ld_go) begin
      exp_data.push_back(expected_load(ld_req));
      exp_req.push_back(ld_req);
    end
    if (st_go) begin
      apply_store(st_req);
      st_issued++;
    end
    if (ld_rsp_valid && ld_rsp_ready) begin
      if (exp_data.size() == 0) stop_run("load response arrived with no load outstanding");
      else check_load(ld_data, exp_data.pop_front(), exp_req.pop_front());
    end
    if (st_rsp_valid && st_rsp_ready) begin
      st_done++;
      if (st_done > st_issued) check_store_count(st_done, st_issued);
    end
  endtask

  task automatic drain();
    while (ld_todo.size() != 0 || st_todo.size() != 0 || ld_req_valid || st_req_valid ||
           exp_data.size() != 0 || st_done != st_issued)
      run_cycle();
  endtask

  initial begin
    #(TOTAL_OPS * 40 * CLK_PERIOD);
    stop_run("timeout, the DUT stopped responding before all operations completed");
  end

  initial begin
    clk = 1'b0;
    rstn = 1'b1;
    ld_req = '0;
    ld_req_valid = 1'b0;
    ld_rsp_ready = 1'b1;
    st_req = '0;
    st_req_valid = 1'b0;
    st_rsp_ready = 1'b1;
    rng_state = 32'h7aad;
    ld_go = 1'b0;
    st_go = 1'b0;
    throttle = 1'b0;
    st_queued = 0;
    st_issued = 0;
    st_done = 0;
    foreach (model[i]) model[i] = 8'h00;
    repeat (3) @(negedge clk);
    rstn = 1'b0;
    #1;
    check_flag(ld_rsp_valid, 1'b0, "ld_rsp_valid");
    check_flag(st_rsp_valid, 1'b0, "st_rsp_valid");
    check_flag(ld_req_ready, 1'b1, "ld_req_ready");
    check_flag(st_req_ready, 1'b1, "st_req_ready");

    // word round trip
    for (int i = 0; i < WORDS_USED; i++) begin
      queue_store(word_addr(i, 2'd0), next_random(), lsu_pkg::st_w);
    end
    drain();
    for (int i = 0; i < WORDS_USED; i++) begin
      queue_load(word_addr(i, 2'd0), lsu_pkg::ld_w);
    end
    drain();

    // byte and halfword merges, read back as words
    for (int i = 0; i < SMALL_STORES; i++) begin
      queue_random_store(1'b0);
    end
    drain();
    for (int i = 0; i < WORDS_USED; i++) begin
      queue_load(word_addr(i, 2'd0), lsu_pkg::ld_w);
    end
    drain();

    // every sub-word load at every legal offset
    for (int i = 0; i < SUB_WORDS; i++) begin
      for (int off = 0; off < 4; off++) begin
        queue_load(word_addr(i, 2'(off)), lsu_pkg::ld_b);
        queue_load(word_addr(i, 2'(off)), lsu_pkg::ld_bu);
      end
      for (int off = 0; off < 4; off += 2) begin
        queue_load(word_addr(i, 2'(off)), lsu_pkg::ld_h);
        queue_load(word_addr(i, 2'(off)), lsu_pkg::ld_hu);
      end
    end
    drain();

    // back-to-back traffic with random response stalls
    throttle = 1'b1;
    for (int n = 0; n < BP_ROUNDS; n++) begin
      for (int i = 0; i < BP_STORES; i++) begin
        queue_random_store(1'b1);
      end
      drain();
      for (int i = 0; i < BP_LOADS; i++) begin
        queue_random_load();
      end
      drain();
    end
    throttle = 1'b0;
    check_store_count(st_done, st_queued);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
